//--- src/sonar_pkg.sv
package sonar_pkg;

    //////////////////////////////////////////////////////////////////////
    // clocking
    //////////////////////////////////////////////////////////////////////

    localparam int clks_per_us = 100;  // 100 MHz board clock

    // divider count inside one microsecond
    typedef logic [$clog2(clks_per_us)-1:0] clk_div_t;

    //////////////////////////////////////////////////////////////////////
    // sensor timing
    //////////////////////////////////////////////////////////////////////

    // microseconds, wide enough for the frame gap and any echo
    typedef logic [21:0] us_count_t;

    localparam int trig_us   = 10;  // HC-SR04 wants at least 10 us
    localparam int us_per_cm = 58;  // round trip, sound at ~343 m/s

    // defaults for the top level
    localparam int default_gap_us     = 60000;  // 60 ms lets old echoes die out
    localparam int default_timeout_us = 30000;  // give up on a missing edge

    //////////////////////////////////////////////////////////////////////
    // per-frame measurement
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      valid;     // frame ended this cycle
        logic      timeout;   // rise or fall never came
        us_count_t width_us;  // echo high time
    } echo_result_t;

    // ranger sequence, one pass per frame
    typedef enum logic [1:0] {
        rs_idle,       // frame gap
        rs_trig,       // trigger pulse high
        rs_wait_high,  // waiting for echo rise
        rs_measure     // echo high, counting
    } ranger_state_t;

endpackage

//--- src/lot_pkg.sv
package lot_pkg;

    import sonar_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // lot size
    //////////////////////////////////////////////////////////////////////

    localparam int num_spots = 4;

    typedef logic [2:0] spot_count_t;  // 0 .. num_spots

    //////////////////////////////////////////////////////////////////////
    // occupancy decision
    //////////////////////////////////////////////////////////////////////

    localparam int th_on_cm  = 5;  // closer than this is a car
    localparam int th_off_cm = 7;  // farther than this is empty

    // same thresholds as echo widths, 290 and 406 us
    localparam us_count_t th_on_us  = us_count_t'(th_on_cm * us_per_cm);
    localparam us_count_t th_off_us = us_count_t'(th_off_cm * us_per_cm);

    typedef logic [7:0] db_count_t;  // saturates at all ones

    localparam db_count_t db_on_frames  = 8'd2;  // hits in a row to park
    localparam db_count_t db_off_frames = 8'd2;  // misses in a row to leave

    localparam bit rgb_active_low = 1'b0;  // common cathode lamp

    typedef enum logic [1:0] {
        fc_hit,   // near, below on threshold
        fc_miss,  // far or no echo
        fc_band   // between thresholds, holds state
    } frame_class_t;

    typedef struct packed {
        logic occupied;  // level
        logic park;      // one cycle on 0 -> 1
        logic leave;     // one cycle on 1 -> 0
    } spot_status_t;

endpackage

//--- src/us_tick_gen.sv
`timescale 1ns/100ps

module us_tick_gen (
    input  logic clk,
    input  logic reset_p,
    output logic tick_us   // high one clk per microsecond
);
    import sonar_pkg::*;

    clk_div_t div_cnt;  // wraps every clks_per_us clocks

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt <= '0;
            tick_us <= 1'b0;
        end else begin
            tick_us <= (div_cnt == clk_div_t'(clks_per_us - 1));  // pulse at wrap
            if (div_cnt == clk_div_t'(clks_per_us - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + clk_div_t'(1);
            end
        end
    end

endmodule

//--- src/echo_ranger.sv
`timescale 1ns/100ps

module echo_ranger #(
    parameter int gap_us     = sonar_pkg::default_gap_us,     // idle time between frames
    parameter int timeout_us = sonar_pkg::default_timeout_us  // limit on each echo edge
) (
    input  logic                    clk,
    input  logic                    reset_p,
    input  logic                    tick_us,  // shared microsecond strobe
    input  logic                    echo,     // raw sensor echo, asynchronous
    output logic                    trig,     // sensor trigger
    output sonar_pkg::echo_result_t result    // one word per frame
);
    import sonar_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // echo synchronizer and edge detect
    //////////////////////////////////////////////////////////////////////

    logic echo_meta;  // first stage, may settle late
    logic echo_sync;  // safe to use
    logic echo_last;  // previous echo_sync
    logic echo_rise;
    logic echo_fall;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            echo_meta <= 1'b0;
            echo_sync <= 1'b0;
            echo_last <= 1'b0;
        end else begin
            echo_meta <= echo;
            echo_sync <= echo_meta;
            echo_last <= echo_sync;
        end
    end

    assign echo_rise = echo_sync & ~echo_last;
    assign echo_fall = ~echo_sync & echo_last;

    //////////////////////////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////////////////////////

    ranger_state_t state;
    ranger_state_t state_nx;
    us_count_t     us_cnt;        // ticks spent in current state
    logic          gap_done;      // last tick of the frame gap
    logic          trig_done;     // last tick of the trigger pulse
    logic          edge_expired;  // waited timeout_us for an edge
    logic          frame_end;
    logic          frame_timeout;

    assign gap_done     = tick_us && (us_cnt == us_count_t'(gap_us - 1));
    assign trig_done    = tick_us && (us_cnt == us_count_t'(trig_us - 1));
    assign edge_expired = tick_us && (us_cnt == us_count_t'(timeout_us - 1));

    always_comb begin
        state_nx = state;
        case (state)
            rs_idle: begin
                if (gap_done) begin
                    state_nx = rs_trig;
                end
            end
            rs_trig: begin
                if (trig_done) begin
                    state_nx = rs_wait_high;
                end
            end
            rs_wait_high: begin
                if (echo_rise) begin
                    state_nx = rs_measure;     // start width count
                end else if (edge_expired) begin
                    state_nx = rs_idle;        // no echo at all
                end
            end
            rs_measure: begin
                if (echo_fall || edge_expired) begin
                    state_nx = rs_idle;        // width done or stuck high
                end
            end
            default: begin
                state_nx = rs_idle;
            end
        endcase
    end

    // frame ends whenever a listening state falls back to idle
    assign frame_end = (state == rs_wait_high || state == rs_measure) &&
                       (state_nx == rs_idle);
    // only a seen fall gives a real width
    assign frame_timeout = !(state == rs_measure && echo_fall);

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state  <= rs_idle;
            us_cnt <= '0;
            trig   <= 1'b0;
        end else begin
            state <= state_nx;
            trig  <= (state_nx == rs_trig);  // aligned with the state register
            if (state_nx != state) begin
                us_cnt <= '0;                // fresh count per state
            end else if (tick_us) begin
                us_cnt <= us_cnt + us_count_t'(1);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // result word
    //////////////////////////////////////////////////////////////////////

    logic      res_valid;
    logic      res_timeout;
    us_count_t res_width;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= frame_end;  // single cycle per frame
        end
    end

    always_ff @(posedge clk) begin
        if (frame_end) begin
            res_timeout <= frame_timeout;
            res_width   <= frame_timeout ? '0 : us_cnt;  // ticks between the edges
        end
    end

    assign result = '{valid: res_valid, timeout: res_timeout, width_us: res_width};

endmodule

//--- src/occupancy_filter.sv
`timescale 1ns/100ps

module occupancy_filter (
    input  logic                    clk,
    input  logic                    reset_p,
    input  sonar_pkg::echo_result_t result,  // from the ranger, valid one cycle
    output lot_pkg::spot_status_t   status
);
    import lot_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // stage 1, hysteresis classification
    //////////////////////////////////////////////////////////////////////

    frame_class_t cls;
    logic         cls_valid;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            cls_valid <= 1'b0;
        end else begin
            cls_valid <= result.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (result.valid) begin
            if (!result.timeout && result.width_us < th_on_us) begin
                cls <= fc_hit;
            end else if (result.timeout || result.width_us > th_off_us) begin
                cls <= fc_miss;   // no echo counts as empty
            end else begin
                cls <= fc_band;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2, frame debounce
    //////////////////////////////////////////////////////////////////////

    db_count_t hit_cnt;
    db_count_t miss_cnt;
    db_count_t hit_cnt_nx;
    db_count_t miss_cnt_nx;
    logic      occupied;
    logic      occ_nx;
    logic      park;
    logic      leave;

    always_comb begin
        hit_cnt_nx  = hit_cnt;
        miss_cnt_nx = miss_cnt;
        occ_nx      = occupied;
        if (cls_valid) begin
            case (cls)
                fc_hit: begin
                    hit_cnt_nx  = (hit_cnt == '1) ? hit_cnt : hit_cnt + db_count_t'(1);
                    miss_cnt_nx = '0;
                    if (hit_cnt_nx >= db_on_frames) begin
                        occ_nx = 1'b1;
                    end
                end
                fc_miss: begin
                    miss_cnt_nx = (miss_cnt == '1) ? miss_cnt : miss_cnt + db_count_t'(1);
                    hit_cnt_nx  = '0;
                    if (miss_cnt_nx >= db_off_frames) begin
                        occ_nx = 1'b0;
                    end
                end
                default: begin
                    occ_nx = occupied;  // band frame, counts untouched
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            hit_cnt  <= '0;
            miss_cnt <= '0;
            occupied <= 1'b0;  // spot starts free
            park     <= 1'b0;
            leave    <= 1'b0;
        end else begin
            hit_cnt  <= hit_cnt_nx;
            miss_cnt <= miss_cnt_nx;
            occupied <= occ_nx;
            park     <= occ_nx & ~occupied;   // 0 -> 1
            leave    <= ~occ_nx & occupied;   // 1 -> 0
        end
    end

    assign status = '{occupied: occupied, park: park, leave: leave};

endmodule

//--- src/parking_spot.sv
`timescale 1ns/100ps

module parking_spot #(
    parameter int gap_us     = sonar_pkg::default_gap_us,
    parameter int timeout_us = sonar_pkg::default_timeout_us
) (
    input  logic                  clk,
    input  logic                  reset_p,
    input  logic                  tick_us,   // shared across the lot
    input  logic                  echo,      // sensor echo pin
    output logic                  trig,      // sensor trigger pin
    output lot_pkg::spot_status_t status,
    output logic                  lamp_r,    // on when occupied
    output logic                  lamp_g     // on when free
);
    import sonar_pkg::*;
    import lot_pkg::*;

    echo_result_t result;  // one word per frame

    //////////////////////////////////////////////////////////////////////
    // sensor side
    //////////////////////////////////////////////////////////////////////

    echo_ranger #(
        .gap_us     (gap_us),
        .timeout_us (timeout_us)
    ) u_ranger (
        .clk     (clk),
        .reset_p (reset_p),
        .tick_us (tick_us),
        .echo    (echo),
        .trig    (trig),
        .result  (result)
    );

    // classify + debounce, status 2 cycles after result.valid
    occupancy_filter u_filter (
        .clk     (clk),
        .reset_p (reset_p),
        .result  (result),
        .status  (status)
    );

    //////////////////////////////////////////////////////////////////////
    // lamp
    //////////////////////////////////////////////////////////////////////

    // xor with polarity flips both colors for a common anode part
    assign lamp_r = status.occupied ^ rgb_active_low;
    assign lamp_g = ~status.occupied ^ rgb_active_low;

endmodule

//--- src/free_space_counter.sv
`timescale 1ns/100ps

module free_space_counter (
    input  logic                                           clk,
    input  logic                                           reset_p,
    input  lot_pkg::spot_status_t [lot_pkg::num_spots-1:0] status,
    output lot_pkg::spot_count_t                           free_count
);
    import lot_pkg::*;

    spot_count_t n_park;   // parks this cycle
    spot_count_t n_leave;  // leaves this cycle

    // several spots may change together, count them all
    always_comb begin
        n_park  = '0;
        n_leave = '0;
        for (int i = 0; i < num_spots; i++) begin
            n_park  = n_park + spot_count_t'(status[i].park);
            n_leave = n_leave + spot_count_t'(status[i].leave);
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            free_count <= spot_count_t'(num_spots);  // whole lot empty
        end else begin
            free_count <= free_count + n_leave - n_park;
        end
    end

endmodule

//--- src/parking_lot_top.sv
`timescale 1ns/100ps

module parking_lot_top #(
    parameter int gap_us     = sonar_pkg::default_gap_us,     // frame gap per spot
    parameter int timeout_us = sonar_pkg::default_timeout_us  // echo edge timeout
) (
    input  logic                                           clk,
    input  logic                                           reset_p,
    input  logic                  [lot_pkg::num_spots-1:0] echo,
    output logic                  [lot_pkg::num_spots-1:0] trig,
    output logic                  [lot_pkg::num_spots-1:0] lamp_r,
    output logic                  [lot_pkg::num_spots-1:0] lamp_g,
    output lot_pkg::spot_status_t [lot_pkg::num_spots-1:0] status,
    output lot_pkg::spot_count_t                           free_count
);
    import lot_pkg::*;

    logic tick_us;  // 1 us strobe for every spot

    us_tick_gen u_tick (
        .clk     (clk),
        .reset_p (reset_p),
        .tick_us (tick_us)
    );

    //////////////////////////////////////////////////////////////////////
    // spots, each free running on its own frame
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < num_spots; i++) begin : g_spot
        parking_spot #(
            .gap_us     (gap_us),
            .timeout_us (timeout_us)
        ) u_spot (
            .clk     (clk),
            .reset_p (reset_p),
            .tick_us (tick_us),
            .echo    (echo[i]),
            .trig    (trig[i]),
            .status  (status[i]),
            .lamp_r  (lamp_r[i]),
            .lamp_g  (lamp_g[i])
        );
    end

    // lot level free count from the park/leave strobes
    free_space_counter u_free (
        .clk        (clk),
        .reset_p    (reset_p),
        .status     (status),
        .free_count (free_count)
    );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 8,  // 125 MHz in sim time
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset_p
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // release on a falling edge, like every other input
    initial begin
        reset_p = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        reset_p = 1'b0;
    end

endmodule

//--- dv/sonar_model.sv
`timescale 1ns/100ps

module sonar_model (
    input  logic clk,
    input  logic trig,      // sensor trigger from the DUT
    input  int   delay_us,  // trigger fall to echo rise
    input  int   width_us,  // echo high time
    input  logic has_echo,  // 0 means nothing comes back
    output logic echo
);
    import sonar_pkg::*;

    logic trig_last;
    int   wait_clks;  // clocks left before the echo rises
    int   high_clks;  // clocks left with echo high

    initial begin
        echo      = 1'b0;
        trig_last = 1'b0;
        wait_clks = 0;
        high_clks = 0;
    end

    //////////////////////////////////////////////////////////////////////
    // playback, everything moves on the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        trig_last <= trig;
        if (trig_last && !trig) begin
            // frame settings are latched here
            if (has_echo) begin
                wait_clks <= delay_us * clks_per_us;
                high_clks <= width_us * clks_per_us;
            end else begin
                wait_clks <= 0;
                high_clks <= 0;
            end
        end else if (wait_clks > 0) begin
            wait_clks <= wait_clks - 1;
            if (wait_clks == 1) begin
                echo <= 1'b1;  // sound came back
            end
        end else if (high_clks > 0) begin
            high_clks <= high_clks - 1;
            if (high_clks == 1) begin
                echo <= 1'b0;  // end of pulse
            end
        end
    end

endmodule

//--- dv/parking_lot_tb.sv
`timescale 1ns/100ps

module parking_lot_tb;
    import sonar_pkg::*;
    import lot_pkg::*;

    localparam int gap_us          = 100;  // short frames for sim
    localparam int timeout_us      = 800;
    localparam int frames_per_spot = 25;
    localparam int watchdog_clks   = (gap_us + trig_us + 2 * timeout_us + 50) * clks_per_us;
    localparam int never           = 32'h7fff_ffff;

    logic                           clk;
    logic                           reset_p;
    wire          [num_spots-1:0]   echo;
    logic         [num_spots-1:0]   trig;
    logic         [num_spots-1:0]   lamp_r;
    logic         [num_spots-1:0]   lamp_g;
    spot_status_t [num_spots-1:0]   status;
    spot_count_t                    free_count;

    int   delay_us [num_spots];   // frame in flight, per spot
    int   width_us [num_spots];
    logic has_echo [num_spots];

    int   seed;
    int   cycle;                  // negedges since reset
    bit   occ_now   [num_spots];  // model after the previous frame
    bit   occ_next  [num_spots];  // model after the frame in flight
    int   hit_run   [num_spots];
    int   miss_run  [num_spots];
    int   exp_park  [num_spots];
    int   exp_leave [num_spots];
    int   got_park  [num_spots];
    int   got_leave [num_spots];
    logic park_last [num_spots];
    logic leave_last[num_spots];
    logic trig_last [num_spots];
    int   rise_at   [num_spots];
    int   rises     [num_spots];
    int   win_lo    [num_spots];  // cycles where the DUT may still update
    int   win_hi    [num_spots];

    tb_clock_gen clock_i (.clk(clk), .reset_p(reset_p));

    for (genvar i = 0; i < num_spots; i++) begin : g_sonar
        sonar_model sonar_i (
            .clk      (clk),
            .trig     (trig[i]),
            .delay_us (delay_us[i]),
            .width_us (width_us[i]),
            .has_echo (has_echo[i]),
            .echo     (echo[i])
        );
    end

    parking_lot_top #(.gap_us(gap_us), .timeout_us(timeout_us)) dut_i (
        .clk        (clk),
        .reset_p    (reset_p),
        .echo       (echo),
        .trig       (trig),
        .lamp_r     (lamp_r),
        .lamp_g     (lamp_g),
        .status     (status),
        .free_count (free_count)
    );

    //////////////////////////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // four-state compare, an x or z never matches
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at %0t: %s is %0d, expected %0d",
                                $time, name, actual, expected));
        end
    endtask

    function automatic int draw_between(input int lo, input int hi);
        draw_between = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic bit is_settled(input int t);
        is_settled = (cycle < win_lo[t]) || (cycle > win_hi[t]);
    endfunction

    function automatic bit settled_occ(input int t);
        settled_occ = (cycle > win_hi[t]) ? occ_next[t] : occ_now[t];
    endfunction

    // pick the next frame and run it through class and debounce
    task automatic plan_frame(input int s);
        int pick;
        bit hit;
        bit miss;
        pick         = draw_between(0, 7);
        delay_us[s]  = draw_between(20, 100);
        has_echo[s]  = (pick != 7);  // 7 is a silent frame
        if (pick <= 2) begin
            width_us[s] = draw_between(50, 280);
        end else if (pick <= 4) begin
            width_us[s] = draw_between(300, 396);  // between thresholds
        end else begin
            width_us[s] = draw_between(416, 700);
        end
        hit  = has_echo[s] && (width_us[s] < th_on_us);
        miss = !has_echo[s] || (width_us[s] > th_off_us);
        if (hit) begin
            hit_run[s]  = (hit_run[s] < 255) ? hit_run[s] + 1 : 255;
            miss_run[s] = 0;
            if (hit_run[s] >= db_on_frames) occ_next[s] = 1'b1;
        end else if (miss) begin
            miss_run[s] = (miss_run[s] < 255) ? miss_run[s] + 1 : 255;
            hit_run[s]  = 0;
            if (miss_run[s] >= db_off_frames) occ_next[s] = 1'b0;
        end
    endtask

    task automatic watch_strobes(input int s);
        if (status[s].park) begin
            check_value($sformatf("status[%0d].park held", s), park_last[s], 0);
            got_park[s]++;
        end
        if (status[s].leave) begin
            check_value($sformatf("status[%0d].leave held", s), leave_last[s], 0);
            got_leave[s]++;
        end
        park_last[s]  = status[s].park;
        leave_last[s] = status[s].leave;
    endtask

    task automatic on_trig_rise(input int s);
        int busy;
        bit all_known;
        if (rises[s] > 0) begin
            check_value($sformatf("trig[%0d] rise spacing ok", s),
                        (cycle - rise_at[s]) >= gap_us * clks_per_us, 1);
        end
        rise_at[s] = cycle;
        rises[s]++;
        if (occ_next[s] && !occ_now[s]) exp_park[s]++;   // previous frame parked
        if (!occ_next[s] && occ_now[s]) exp_leave[s]++;
        occ_now[s] = occ_next[s];
        win_lo[s]  = never;
        win_hi[s]  = never;
        check_value($sformatf("status[%0d].occupied", s), status[s].occupied, occ_now[s]);
        check_value($sformatf("park count[%0d]", s), got_park[s], exp_park[s]);
        check_value($sformatf("leave count[%0d]", s), got_leave[s], exp_leave[s]);
        check_value($sformatf("lamp_r[%0d]", s), lamp_r[s], occ_now[s]);
        check_value($sformatf("lamp_g[%0d]", s), lamp_g[s], !occ_now[s]);
        busy      = 0;
        all_known = 1'b1;
        for (int t = 0; t < num_spots; t++) begin
            busy      = busy + settled_occ(t);
            all_known = all_known & is_settled(t);
        end
        // another spot mid-update makes the count ambiguous for a few cycles
        if (all_known) begin
            check_value("free_count", free_count, num_spots - busy);
        end
        plan_frame(s);
    endtask

    task automatic on_trig_fall(input int s);
        int len;
        int end_at;
        len = cycle - rise_at[s];
        check_value($sformatf("trig[%0d] pulse in 9..12 us", s),
                    (len >= 9 * clks_per_us) && (len <= 12 * clks_per_us), 1);
        if (has_echo[s]) begin
            end_at    = cycle + (delay_us[s] + width_us[s]) * clks_per_us;  // echo fall
            win_lo[s] = end_at + 1;
            win_hi[s] = end_at + 8;
        end else begin
            end_at    = cycle + timeout_us * clks_per_us;  // ranger gives up
            win_lo[s] = end_at - clks_per_us;
            win_hi[s] = end_at + clks_per_us + 8;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int wait_clks;
        bit all_done;
        seed  = 32'h010fdaba;
        cycle = 0;
        for (int s = 0; s < num_spots; s++) begin
            delay_us[s]  = 20;
            width_us[s]  = 0;
            has_echo[s]  = 1'b0;
            occ_now[s]   = 1'b0;
            occ_next[s]  = 1'b0;
            hit_run[s]   = 0;
            miss_run[s]  = 0;
            exp_park[s]  = 0;
            exp_leave[s] = 0;
            got_park[s]  = 0;
            got_leave[s] = 0;
            park_last[s] = 1'b0;
            leave_last[s] = 1'b0;
            trig_last[s] = 1'b0;
            rise_at[s]   = 0;
            rises[s]     = 0;
            win_lo[s]    = -1;  // nothing in flight
            win_hi[s]    = -1;
        end

        wait_clks = 0;
        while (reset_p !== 1'b0) begin
            @(negedge clk);
            wait_clks++;
            if (wait_clks > 100) abort_run("reset_p was never released");
        end
        @(negedge clk);

        // state right after reset
        for (int s = 0; s < num_spots; s++) begin
            check_value($sformatf("trig[%0d]", s), trig[s], 0);
            check_value($sformatf("status[%0d].occupied", s), status[s].occupied, 0);
            check_value($sformatf("lamp_r[%0d]", s), lamp_r[s], 0);
            check_value($sformatf("lamp_g[%0d]", s), lamp_g[s], 1);
        end
        check_value("free_count", free_count, num_spots);

        all_done = 1'b0;
        while (!all_done) begin
            @(negedge clk);
            cycle++;
            all_done = 1'b1;
            for (int s = 0; s < num_spots; s++) begin
                watch_strobes(s);
                if (trig[s] && !trig_last[s]) on_trig_rise(s);
                if (!trig[s] && trig_last[s]) on_trig_fall(s);
                trig_last[s] = trig[s];
                if (cycle - rise_at[s] > watchdog_clks) begin
                    abort_run($sformatf("spot %0d saw no trigger rise for %0d cycles",
                                        s, watchdog_clks));
                end
                if (rises[s] <= frames_per_spot) all_done = 1'b0;
            end
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- build.f
src/sonar_pkg.sv
src/lot_pkg.sv
src/us_tick_gen.sv
src/echo_ranger.sv
src/occupancy_filter.sv
src/parking_spot.sv
src/free_space_counter.sv
src/parking_lot_top.sv
dv/tb_clock_gen.sv
dv/sonar_model.sv
dv/parking_lot_tb.sv
